// File: aes_ke_cfg.svh
//////////////////////////////
// AES key expansion constants
// Word and key widths, round counter width
// Rcon start values per direction and key length
//////////////////////////////

`ifndef AES_KE_CFG_SVH
`define AES_KE_CFG_SVH

// One key word, four bytes
`define AES_KE_WORD_W 32

// Full key register holds eight words (AES-256 size)
`define AES_KE_NUM_WORDS 8

// Round counter width, covers rounds 0 to 14
`define AES_KE_ROUND_W 4

// Rcon start values loaded on clear
`define AES_KE_RCON_FWD_INIT 8'h01
`define AES_KE_RCON_INV_128 8'h36
`define AES_KE_RCON_INV_256 8'h40

`endif

// File: aes_ke_pkg.sv
//////////////////////////////
// AES key expansion package
// Direction and key length enums, key types
// GF(2^8) helpers and RotWord
//////////////////////////////

`default_nettype none

`include "aes_ke_cfg.svh"

package aes_ke_pkg;

  // Direction of the key schedule
  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // Supported key lengths, AES-192 not supported
  typedef enum logic {
    AES_128 = 1'b0,
    AES_256 = 1'b1
  } key_len_e;

  typedef logic [`AES_KE_WORD_W-1:0] key_word_t;
  typedef logic [`AES_KE_NUM_WORDS-1:0][`AES_KE_WORD_W-1:0] key_full_t;

  // Multiply by x, reduce with the AES polynomial
  function automatic logic [7:0] aes_mul2(logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // Divide by x, inverse of aes_mul2
  function automatic logic [7:0] aes_div2(logic [7:0] b);
    logic [7:0] res;
    res[7] = b[0];
    res[6] = b[7];
    res[5] = b[6];
    res[4] = b[5];
    res[3] = b[4] ^ b[0];
    res[2] = b[3] ^ b[0];
    res[1] = b[2];
    res[0] = b[1] ^ b[0];
    return res;
  endfunction

  // RotWord, lowest byte moves to the top
  function automatic key_word_t aes_rot_word(key_word_t w);
    return {w[7:0], w[`AES_KE_WORD_W-1:8]};
  endfunction

endpackage

`default_nettype wire

// File: aes_sbox.sv
//////////////////////////////
// Forward AES S-box
// Plain 256-entry constant table
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module aes_sbox (
  input  logic [7:0] data_i,
  output logic [7:0] data_o
);

  // Forward substitution table, indexed by the input byte
  // Eight entries per line, two lines per row of the usual 16x16 table
  localparam logic [7:0] sbox_lut [256] = '{
    // 0x00
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    // 0x40
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    // 0x80
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    // 0xc0
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // Pure lookup, no clock
  assign data_o = sbox_lut[data_i];

endmodule

`default_nettype wire

// File: aes_rcon.sv
//////////////////////////////
// Rcon register
// Clear and update rules, Rcon usage decode
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "aes_ke_cfg.svh"

module aes_rcon (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  aes_ke_pkg::ciph_op_e       op_i,
  input  aes_ke_pkg::key_len_e       key_len_i,
  input  logic [`AES_KE_ROUND_W-1:0] round_i,
  input  logic                       clear_i,
  input  logic                       en_i,
  input  logic                       out_ack_i,
  output logic [7:0]                 rcon_o,
  output logic                       use_rcon_o
);

  import aes_ke_pkg::*;

  logic [7:0] rcon_d, rcon_q;
  logic [7:0] rcon_init;
  logic       rcon_we;

  // AES-256 even rounds only do SubWord, so no RotWord and no Rcon
  assign use_rcon_o = !((key_len_i == AES_256) && !round_i[0]);

  // Start value depends on direction and, for inverse, on key length
  always_comb begin
    if (op_i == CIPH_FWD) begin
      rcon_init = `AES_KE_RCON_FWD_INIT;
    end else if (key_len_i == AES_128) begin
      rcon_init = `AES_KE_RCON_INV_128;
    end else begin
      rcon_init = `AES_KE_RCON_INV_256;
    end
  end

  // Clear wins over the update
  assign rcon_d = clear_i           ? rcon_init        :
                  (op_i == CIPH_FWD) ? aes_mul2(rcon_q) : aes_div2(rcon_q);

  // out_req equals en, so a handshake is en & ack
  assign rcon_we = clear_i | (use_rcon_o & en_i & out_ack_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rcon_q <= '0;
    end else if (rcon_we) begin
      rcon_q <= rcon_d;
    end
  end

  assign rcon_o = rcon_q;

endmodule

`default_nettype wire

// File: aes_key_irregular.sv
//////////////////////////////
// Irregular key word
// Source select, RotWord, SubWord, Rcon add
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "aes_ke_cfg.svh"

module aes_key_irregular (
  input  aes_ke_pkg::ciph_op_e  op_i,
  input  aes_ke_pkg::key_len_e  key_len_i,
  input  aes_ke_pkg::key_full_t key_i,
  input  logic [7:0]            rcon_i,
  input  logic                  use_rcon_i,
  output aes_ke_pkg::key_word_t irregular_o
);

  import aes_ke_pkg::*;

  localparam int num_bytes = `AES_KE_WORD_W / 8;

  key_word_t spec_in_128;
  key_word_t rot_word_in;
  key_word_t sub_word_in;
  key_word_t sub_word_out;
  key_word_t rcon_added;

  // Inverse AES-128 needs the word that forward expansion produced as word 3
  assign spec_in_128 = key_i[3] ^ key_i[2];

  ////////////////////////////////
  // Source word select
  ////////////////////////////////

  always_comb begin
    unique case (key_len_i)
      AES_128: begin
        rot_word_in = (op_i == CIPH_FWD) ? key_i[3] : spec_in_128;
      end
      AES_256: begin
        rot_word_in = (op_i == CIPH_FWD) ? key_i[7] : key_i[3];
      end
      default: begin
        rot_word_in = key_i[3];
      end
    endcase
  end

  // RotWord and Rcon share one enable
  assign sub_word_in = use_rcon_i ? aes_rot_word(rot_word_in) : rot_word_in;

  ////////////////////////////////
  // SubWord
  ////////////////////////////////

  // One table S-box per byte
  for (genvar i = 0; i < num_bytes; i++) begin : gen_sbox
    aes_sbox u_aes_sbox (
      .data_i ( sub_word_in[8*i +: 8]  ),
      .data_o ( sub_word_out[8*i +: 8] )
    );
  end

  // Rcon only touches the low byte
  assign rcon_added = {sub_word_out[`AES_KE_WORD_W-1:8], sub_word_out[7:0] ^ rcon_i};

  assign irregular_o = use_rcon_i ? rcon_added : sub_word_out;

endmodule

`default_nettype wire

// File: aes_key_regular.sv
//////////////////////////////
// Regular part of the key schedule
// XOR chains per key length and direction
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "aes_ke_cfg.svh"

module aes_key_regular (
  input  aes_ke_pkg::ciph_op_e       op_i,
  input  aes_ke_pkg::key_len_e       key_len_i,
  input  logic [`AES_KE_ROUND_W-1:0] round_i,
  input  aes_ke_pkg::key_full_t      key_i,
  input  aes_ke_pkg::key_word_t      irregular_i,
  output aes_ke_pkg::key_full_t      key_o
);

  import aes_ke_pkg::*;

  key_full_t regular;
  key_full_t swapped;

  // Halves swapped, also the fallback for unused cases
  assign swapped = {key_i[3:0], key_i[7:4]};

  always_comb begin
    regular = swapped;

    unique case (key_len_i)

      ////////////////////////////////
      // AES-128
      ////////////////////////////////
      AES_128: begin
        // Upper words unused, reuse the lower input words
        regular[7:4] = key_i[3:0];
        regular[0]   = irregular_i ^ key_i[0];
        if (op_i == CIPH_FWD) begin
          // Chain through the freshly built words
          for (int i = 1; i < 4; i++) begin
            regular[i] = regular[i-1] ^ key_i[i];
          end
        end else begin
          // Inverse only needs neighbouring input words
          for (int i = 1; i < 4; i++) begin
            regular[i] = key_i[i-1] ^ key_i[i];
          end
        end
      end

      ////////////////////////////////
      // AES-256
      ////////////////////////////////
      AES_256: begin
        if (round_i == '0) begin
          // Round 0 just swaps halves, no new words
          regular = swapped;
        end else if (op_i == CIPH_FWD) begin
          // Old upper half moves down
          regular[3:0] = key_i[7:4];
          // New upper half
          regular[4]   = irregular_i ^ key_i[0];
          for (int i = 1; i < 4; i++) begin
            regular[i+4] = regular[i+3] ^ key_i[i];
          end
        end else begin
          // Old lower half moves up
          regular[7:4] = key_i[3:0];
          // New lower half
          regular[0]   = irregular_i ^ key_i[4];
          for (int i = 0; i < 3; i++) begin
            regular[i+1] = key_i[4+i] ^ key_i[5+i];
          end
        end
      end

      default: begin
        regular = swapped;
      end
    endcase
  end

  assign key_o = regular;

endmodule

`default_nettype wire

// File: aes_key_expand.sv
//////////////////////////////
// AES-128/256 key expansion top
// Rcon, irregular word and regular words
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "aes_ke_cfg.svh"

module aes_key_expand (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  aes_ke_pkg::ciph_op_e       op_i,
  input  logic                       en_i,
  output logic                       out_req_o,
  input  logic                       out_ack_i,
  input  logic                       clear_i,
  input  logic [`AES_KE_ROUND_W-1:0] round_i,
  input  aes_ke_pkg::key_len_e       key_len_i,
  input  aes_ke_pkg::key_full_t      key_i,
  output aes_ke_pkg::key_full_t      key_o
);

  import aes_ke_pkg::*;

  logic [7:0] rcon;
  logic       use_rcon;
  key_word_t  irregular;

  // Rcon register and its usage decode
  aes_rcon u_aes_rcon (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .op_i       ( op_i      ),
    .key_len_i  ( key_len_i ),
    .round_i    ( round_i   ),
    .clear_i    ( clear_i   ),
    .en_i       ( en_i      ),
    .out_ack_i  ( out_ack_i ),
    .rcon_o     ( rcon      ),
    .use_rcon_o ( use_rcon  )
  );

  // RotWord, SubWord and Rcon add
  aes_key_irregular u_aes_key_irregular (
    .op_i        ( op_i      ),
    .key_len_i   ( key_len_i ),
    .key_i       ( key_i     ),
    .rcon_i      ( rcon      ),
    .use_rcon_i  ( use_rcon  ),
    .irregular_o ( irregular )
  );

  // XOR chains build the next full key
  aes_key_regular u_aes_key_regular (
    .op_i        ( op_i      ),
    .key_len_i   ( key_len_i ),
    .round_i     ( round_i   ),
    .key_i       ( key_i     ),
    .irregular_i ( irregular ),
    .key_o       ( key_o     )
  );

  // Table S-boxes are combinational, result ready in the same cycle
  assign out_req_o = en_i;

endmodule

`default_nettype wire

// File: tb_aes_key_check.sv
//////////////////////////////
// Key expansion checker
// Reference model with own S-box and Rcon
// Handshake, request and back-pressure checks
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "aes_ke_cfg.svh"

module tb_aes_key_check (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  aes_ke_pkg::ciph_op_e       op_i,
  input  aes_ke_pkg::key_len_e       key_len_i,
  input  logic [`AES_KE_ROUND_W-1:0] round_i,
  input  logic                       clear_i,
  input  logic                       en_i,
  input  logic                       out_req_i,
  input  logic                       out_ack_i,
  input  aes_ke_pkg::key_full_t      key_in_i,
  input  aes_ke_pkg::key_full_t      key_out_i,
  output int                         check_cnt_o,
  output int                         error_cnt_o
);

  import aes_ke_pkg::*;

  logic [7:0] sbox_ref [256];
  logic [7:0] rcon_q;
  logic       stall_q;
  key_full_t  key_in_q;
  key_full_t  key_out_q;

  // Multiply and divide by x modulo x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] xtime(logic [7:0] b);
    return b[7] ? ({b[6:0], 1'b0} ^ 8'h1b) : {b[6:0], 1'b0};
  endfunction

  function automatic logic [7:0] xdiv(logic [7:0] b);
    return b[0] ? (((b ^ 8'h1b) >> 1) | 8'h80) : (b >> 1);
  endfunction

  function automatic logic [7:0] gf_mult(logic [7:0] a, logic [7:0] b);
    logic [7:0] p;
    p = '0;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) p ^= a;
      a = xtime(a);
    end
    return p;
  endfunction

  // S-box built from the field inverse and the affine map
  initial begin : build_sbox
    logic [7:0] inv;
    logic [7:0] sq;
    logic [7:0] rot;
    for (int x = 0; x < 256; x++) begin
      inv = 8'h01;
      sq  = 8'(x);
      // x^254 = x^2 * x^4 * ... * x^128
      for (int k = 0; k < 7; k++) begin
        sq  = gf_mult(sq, sq);
        inv = gf_mult(inv, sq);
      end
      rot         = inv;
      sbox_ref[x] = inv ^ 8'h63;
      for (int k = 0; k < 4; k++) begin
        rot         = {rot[6:0], rot[7]};
        sbox_ref[x] = sbox_ref[x] ^ rot;
      end
    end
  end

  // Expected next key from the schedule rules
  function automatic key_full_t ref_next_key(ciph_op_e op, key_len_e len,
      logic [`AES_KE_ROUND_W-1:0] rnd, key_full_t k, logic [7:0] rc);
    key_word_t src;
    key_word_t w;
    key_full_t n;
    logic      use_rc;
    use_rc = !(len == AES_256 && !rnd[0]);
    if (len == AES_128) src = (op == CIPH_FWD) ? k[3] : (k[3] ^ k[2]);
    else src = (op == CIPH_FWD) ? k[7] : k[3];
    // RotWord moves the low byte to the top
    if (use_rc) src = {src[7:0], src[31:8]};
    for (int b = 0; b < 4; b++) w[8*b +: 8] = sbox_ref[src[8*b +: 8]];
    if (use_rc) w[7:0] = w[7:0] ^ rc;
    if (len == AES_128) begin
      n[7:4] = k[3:0];
      n[0]   = w ^ k[0];
      for (int i = 1; i < 4; i++) n[i] = (op == CIPH_FWD) ? (n[i-1] ^ k[i]) : (k[i-1] ^ k[i]);
    end else if (rnd == '0) begin
      n = {k[3:0], k[7:4]};
    end else if (op == CIPH_FWD) begin
      n[3:0] = k[7:4];
      n[4]   = w ^ k[0];
      for (int i = 1; i < 4; i++) n[i+4] = n[i+3] ^ k[i];
    end else begin
      n[7:4] = k[3:0];
      n[0]   = w ^ k[4];
      for (int i = 0; i < 3; i++) n[i+1] = k[4+i] ^ k[5+i];
    end
    return n;
  endfunction

  task automatic check_key(input string name, input key_full_t exp, input key_full_t act);
    check_cnt_o++;
    if (act !== exp) begin
      error_cnt_o++;
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // Model Rcon and compare, all on values from before the edge
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rcon_q  <= '0;
      stall_q <= 1'b0;
    end else begin
      if (out_req_i !== en_i) begin
        error_cnt_o++;
        $display("Error at %0t ns: out_req_o expected %b, got %b", $time, en_i, out_req_i);
      end
      // Stalled round with unchanged key keeps its result
      if (stall_q && key_in_i === key_in_q) begin
        check_key("key_o under back-pressure", key_out_q, key_out_i);
      end
      if (out_req_i && out_ack_i) begin
        check_key("key_o", ref_next_key(op_i, key_len_i, round_i, key_in_i, rcon_q), key_out_i);
      end
      if (clear_i) begin
        if (op_i == CIPH_FWD) rcon_q <= `AES_KE_RCON_FWD_INIT;
        else if (key_len_i == AES_128) rcon_q <= `AES_KE_RCON_INV_128;
        else rcon_q <= `AES_KE_RCON_INV_256;
      end else if (out_req_i && out_ack_i && !(key_len_i == AES_256 && !round_i[0])) begin
        rcon_q <= (op_i == CIPH_FWD) ? xtime(rcon_q) : xdiv(rcon_q);
      end
      stall_q   <= en_i && !out_ack_i;
      key_in_q  <= key_in_i;
      key_out_q <= key_out_i;
    end
  end

endmodule

`default_nettype wire

// File: tb_aes_key_expand.sv
//////////////////////////////
// Key expansion testbench top
// Clock, reset, round sequences, DUT
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "aes_ke_cfg.svh"

module tb_aes_key_expand;

  import aes_ke_pkg::*;

  // Cycles allowed for one handshake
  localparam int HsTimeout = 50;

  logic                       clk_i = 1'b0;
  logic                       rst_ni;
  ciph_op_e                   op;
  key_len_e                   key_len;
  logic [`AES_KE_ROUND_W-1:0] round;
  logic                       clear;
  logic                       en;
  logic                       out_ack;
  logic                       out_req;
  key_full_t                  key_in;
  key_full_t                  key_out;
  key_full_t                  orig_key;
  key_full_t                  recovered;
  int                         check_cnt;
  int                         error_cnt;
  int                         timeout_cnt;
  bit                         aborted;

  always #4 clk_i = ~clk_i;

  aes_key_expand i_dut (
    .clk_i     ( clk_i   ),
    .rst_ni    ( rst_ni  ),
    .op_i      ( op      ),
    .en_i      ( en      ),
    .out_req_o ( out_req ),
    .out_ack_i ( out_ack ),
    .clear_i   ( clear   ),
    .round_i   ( round   ),
    .key_len_i ( key_len ),
    .key_i     ( key_in  ),
    .key_o     ( key_out )
  );

  tb_aes_key_check i_check (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .op_i        ( op        ),
    .key_len_i   ( key_len   ),
    .round_i     ( round     ),
    .clear_i     ( clear     ),
    .en_i        ( en        ),
    .out_req_i   ( out_req   ),
    .out_ack_i   ( out_ack   ),
    .key_in_i    ( key_in    ),
    .key_out_i   ( key_out   ),
    .check_cnt_o ( check_cnt ),
    .error_cnt_o ( error_cnt )
  );

  task automatic load_random_key(output key_full_t k);
    for (int i = 0; i < `AES_KE_NUM_WORDS; i++) k[i] = $urandom;
    @(posedge clk_i);
    key_in <= k;
  endtask

  // One round, ack held back for a random number of cycles
  task automatic do_round(input int rnd, input int max_stall);
    int stall;
    int waited;
    bit done;
    stall  = $urandom_range(max_stall, 0);
    waited = 0;
    done   = 1'b0;
    @(posedge clk_i);
    round   <= rnd[`AES_KE_ROUND_W-1:0];
    en      <= 1'b1;
    out_ack <= (stall == 0);
    while (!done && waited < HsTimeout) begin
      @(posedge clk_i);
      if (out_req && out_ack) begin
        done = 1'b1;
        // Cipher core writes the round key back
        key_in  <= key_out;
        en      <= 1'b0;
        out_ack <= 1'b0;
      end else begin
        waited++;
        if (waited >= stall) out_ack <= 1'b1;
      end
    end
    if (!done) begin
      $display("Timeout at %0t ns: no handshake in round %0d", $time, rnd);
      timeout_cnt++;
      aborted = 1'b1;
    end
  endtask

  // Clear pulse, then rounds first to last
  task automatic run_seq(input ciph_op_e o, input key_len_e l, input int first,
                         input int last, input int max_stall);
    @(posedge clk_i);
    op      <= o;
    key_len <= l;
    clear   <= 1'b1;
    @(posedge clk_i);
    clear   <= 1'b0;
    for (int r = first; r <= last && !aborted; r++) begin
      do_round(r, max_stall);
    end
  endtask

  initial begin
    void'($urandom(32'h67a81284));
    rst_ni  = 1'b0;
    op      = CIPH_FWD;
    key_len = AES_128;
    round   = '0;
    clear   = 1'b0;
    en      = 1'b0;
    out_ack = 1'b0;
    key_in  = '0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    // AES-128 forward, then inverse back to the start key
    load_random_key(orig_key);
    run_seq(CIPH_FWD, AES_128, 1, 10, 3);
    if (!aborted) run_seq(CIPH_INV, AES_128, 1, 10, 3);
    if (!aborted) begin
      @(posedge clk_i);
      recovered      = orig_key;
      recovered[3:0] = key_in[3:0];
      i_check.check_key("key_o[3:0] after inverse", orig_key, recovered);
    end

    // AES-256 both directions, inverse from the final forward state
    if (!aborted) load_random_key(orig_key);
    if (!aborted) run_seq(CIPH_FWD, AES_256, 0, 14, 3);
    if (!aborted) run_seq(CIPH_INV, AES_256, 0, 14, 3);

    // Long ack stalls
    if (!aborted) load_random_key(orig_key);
    if (!aborted) run_seq(CIPH_FWD, AES_128, 1, 4, 12);
    if (!aborted) run_seq(CIPH_FWD, AES_256, 0, 5, 12);

    // Clear in the middle restarts Rcon
    if (!aborted) run_seq(CIPH_FWD, AES_128, 1, 4, 2);
    if (!aborted) run_seq(CIPH_FWD, AES_128, 1, 3, 2);

    repeat (2) @(posedge clk_i);
    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_cnt, error_cnt, timeout_cnt);
    if (error_cnt == 0 && timeout_cnt == 0 && check_cnt > 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
aes_ke_pkg.sv
aes_sbox.sv
aes_rcon.sv
aes_key_irregular.sv
aes_key_regular.sv
aes_key_expand.sv
tb_aes_key_check.sv
tb_aes_key_expand.sv
